// File: Bender.yml
package:
  name: stream_join

sources:
  - join_pkg.sv
  - stream_sequencer.sv
  - byte_packer.sv
  - skid_buffer.sv
  - stream_join.sv
  - target: test
    files:
      - tb_stream_join.sv

// File: byte_packer.sv
// ----------------------------------------
// byte packer: packs partial words of the
// merged stream into full output words.
// ----------------------------------------

`timescale 1ns/1ps

module byte_packer (
   input  logic                  clk,
   input  logic                  resetn,

   input  join_pkg::stream_word_t merged_word,
   input  logic                  merged_valid,
   output logic                  merged_ready,

   output join_pkg::stream_word_t packed_word,
   output logic                  packed_valid,
   input  logic                  packed_ready
);

   localparam int db = join_pkg::data_bytes;
   localparam int cw = join_pkg::byte_count_w;

   // held bytes, never a full word.
   logic [db-2:0][7:0]     carry_data;
   logic [cw-1:0]          carry_cnt;
   join_pkg::stream_meta_t carry_meta;

   // held bytes close a packet and go out on their own.
   logic flush_pending;

   // held bytes followed by the new word.
   logic [2*db-1:0][7:0] comb_data;
   logic [cw-1:0]        new_cnt;
   logic [cw:0]          total;
   logic [cw:0]          total_rem;

   logic accept;
   logic can_emit;
   logic do_flush;
   logic full_word;

   // number of set bits in a contiguous keep.
   function automatic logic [cw-1:0] keep_count(input logic [db-1:0] keep);
      logic [cw-1:0] cnt;
      cnt = '0;
      for (int i = 0; i < db; i++) begin
         if (keep[i]) begin
            cnt = cnt + 1'b1;
         end
      end
      return cnt;
   endfunction

   // keep with the lowest cnt bytes set.
   function automatic logic [db-1:0] keep_mask(input logic [cw-1:0] cnt);
      logic [db-1:0] mask;
      for (int i = 0; i < db; i++) begin
         mask[i] = (i < cnt);
      end
      return mask;
   endfunction

   assign can_emit     = !packed_valid || packed_ready;
   assign merged_ready = can_emit && !flush_pending;
   assign accept       = merged_valid && merged_ready;
   assign do_flush     = flush_pending && can_emit;

   assign new_cnt   = keep_count(merged_word.keep);
   assign total     = {1'b0, carry_cnt} + {1'b0, new_cnt};
   assign total_rem = total - (cw + 1)'(db);
   assign full_word = (total >= db);

   // ----------------------------------------
   // byte realignment
   // ----------------------------------------

   always_comb begin
      for (int i = 0; i < 2 * db; i++) begin
         if (i < carry_cnt) begin
            comb_data[i] = carry_data[i];
         end else if (i < carry_cnt + db) begin
            comb_data[i] = merged_word.data[i - carry_cnt];
         end else begin
            comb_data[i] = 8'h00;
         end
      end
   end

   // ----------------------------------------
   // control
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (!resetn) begin
         carry_cnt     <= '0;
         flush_pending <= 1'b0;
         packed_valid  <= 1'b0;
      end else begin
         if (packed_valid && packed_ready) begin
            packed_valid <= 1'b0;
         end
         if (do_flush) begin
            packed_valid  <= 1'b1;
            carry_cnt     <= '0;
            flush_pending <= 1'b0;
         end else if (accept) begin
            if (full_word) begin
               packed_valid  <= 1'b1;
               carry_cnt     <= total_rem[cw-1:0];
               flush_pending <= merged_word.last && (total > db);
            end else if (merged_word.last) begin
               packed_valid <= 1'b1;
               carry_cnt    <= '0;
            end else begin
               carry_cnt <= total[cw-1:0];
            end
         end
      end
   end

   // ----------------------------------------
   // data path
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (do_flush) begin
         packed_word.data <= {{8'h00}, carry_data};
         packed_word.keep <= keep_mask(carry_cnt);
         packed_word.last <= 1'b1;
         packed_word.meta <= carry_meta;
      end else if (accept) begin
         packed_word.data <= comb_data[db-1:0];
         packed_word.meta <= merged_word.meta;
         carry_meta       <= merged_word.meta;
         if (full_word) begin
            packed_word.keep <= '1;
            // last only when nothing is left over.
            packed_word.last <= merged_word.last && (total == db);
            carry_data       <= comb_data[2*db-2:db];
         end else begin
            packed_word.keep <= keep_mask(total[cw-1:0]);
            packed_word.last <= 1'b1;
            carry_data       <= comb_data[db-2:0];
         end
      end
   end

endmodule

// File: join_pkg.sv
// ----------------------------------------
// shared widths and types for the header
// and payload stream join.
// ----------------------------------------

package join_pkg;

   // bytes per stream word.
   localparam int data_bytes = 8;

   // byte count from 0 up to data_bytes.
   localparam int byte_count_w = 4;

   // sideband widths.
   localparam int tid_w   = 4;
   localparam int tdest_w = 4;

   // ----------------------------------------
   // stream types
   // ----------------------------------------

   // per-packet sideband, constant over a whole packet.
   typedef struct packed {
      logic [tid_w-1:0]   tid;
      logic [tdest_w-1:0] tdest;
   } stream_meta_t;

   // one stream word; byte 0 is the first byte on the wire.
   typedef struct packed {
      logic [data_bytes-1:0][7:0] data;
      // contiguous from byte 0.
      logic [data_bytes-1:0]      keep;
      logic                       last;
      stream_meta_t               meta;
   } stream_word_t;

   // ----------------------------------------
   // sequencer state
   // ----------------------------------------

   typedef enum logic {
      seq_header,
      seq_payload
   } seq_state_t;

endpackage

// File: skid_buffer.sv
// ----------------------------------------
// two-entry output slice with a registered
// ready toward the packer.
// ----------------------------------------

`timescale 1ns/1ps

module skid_buffer (
   input  logic                  clk,
   input  logic                  resetn,

   input  join_pkg::stream_word_t packed_word,
   input  logic                  packed_valid,
   output logic                  packed_ready,

   output join_pkg::stream_word_t out_word,
   output logic                  out_valid,
   input  logic                  out_ready
);

   join_pkg::stream_word_t skid_word;
   logic                   skid_valid;

   logic main_free;

   // free when empty or drained this cycle.
   assign main_free = !out_valid || out_ready;

   // only the fill level sets ready.
   assign packed_ready = !skid_valid;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (main_free) begin
         if (skid_valid) begin
            out_valid  <= 1'b1;
            skid_valid <= 1'b0;
         end else begin
            out_valid <= packed_valid;
         end
      end else if (packed_valid && packed_ready) begin
         skid_valid <= 1'b1;
      end
   end

   // older word in the skid goes out first.
   always_ff @(posedge clk) begin
      if (main_free) begin
         out_word <= skid_valid ? skid_word : packed_word;
      end else if (packed_valid && packed_ready) begin
         skid_word <= packed_word;
      end
   end

endmodule

// File: stream_join.sv
// ----------------------------------------
// joins a header stream and a payload
// stream into one packed packet stream.
// ----------------------------------------

`timescale 1ns/1ps

module stream_join (
   input  logic                  clk,
   input  logic                  resetn,

   input  join_pkg::stream_word_t hdr_word,
   input  logic                  hdr_valid,
   output logic                  hdr_ready,

   input  join_pkg::stream_word_t pyld_word,
   input  logic                  pyld_valid,
   output logic                  pyld_ready,

   output join_pkg::stream_word_t out_word,
   output logic                  out_valid,
   input  logic                  out_ready
);

   join_pkg::stream_word_t merged_word;
   logic                   merged_valid;
   logic                   merged_ready;

   join_pkg::stream_word_t packed_word;
   logic                   packed_valid;
   logic                   packed_ready;

   stream_sequencer seq_inst (
      .clk          (clk),
      .resetn       (resetn),
      .hdr_word     (hdr_word),
      .hdr_valid    (hdr_valid),
      .hdr_ready    (hdr_ready),
      .pyld_word    (pyld_word),
      .pyld_valid   (pyld_valid),
      .pyld_ready   (pyld_ready),
      .merged_word  (merged_word),
      .merged_valid (merged_valid),
      .merged_ready (merged_ready)
   );

   byte_packer packer_inst (
      .clk          (clk),
      .resetn       (resetn),
      .merged_word  (merged_word),
      .merged_valid (merged_valid),
      .merged_ready (merged_ready),
      .packed_word  (packed_word),
      .packed_valid (packed_valid),
      .packed_ready (packed_ready)
   );

   skid_buffer skid_inst (
      .clk          (clk),
      .resetn       (resetn),
      .packed_word  (packed_word),
      .packed_valid (packed_valid),
      .packed_ready (packed_ready),
      .out_word     (out_word),
      .out_valid    (out_valid),
      .out_ready    (out_ready)
   );

endmodule

// File: stream_sequencer.sv
// ----------------------------------------
// stream sequencer: passes one whole header
// packet, then its payload, as one stream.
// ----------------------------------------

`timescale 1ns/1ps

module stream_sequencer (
   input  logic                  clk,
   input  logic                  resetn,

   input  join_pkg::stream_word_t hdr_word,
   input  logic                  hdr_valid,
   output logic                  hdr_ready,

   input  join_pkg::stream_word_t pyld_word,
   input  logic                  pyld_valid,
   output logic                  pyld_ready,

   output join_pkg::stream_word_t merged_word,
   output logic                  merged_valid,
   input  logic                  merged_ready
);

   join_pkg::seq_state_t state;
   join_pkg::seq_state_t state_nxt;

   // high until the first header word of a packet is taken.
   logic start;

   // sideband of the first header word.
   join_pkg::stream_meta_t meta_q;

   logic hdr_take;
   logic pyld_take;

   assign hdr_take  = hdr_valid && hdr_ready;
   assign pyld_take = pyld_valid && pyld_ready;

   // ----------------------------------------
   // input select
   // ----------------------------------------

   always_comb begin
      merged_word      = hdr_word;
      merged_valid     = hdr_valid;
      hdr_ready        = merged_ready;
      pyld_ready       = 1'b0;
      // the header end is not the packet end.
      merged_word.last = 1'b0;
      merged_word.meta = start ? hdr_word.meta : meta_q;
      if (state == join_pkg::seq_payload) begin
         merged_word      = pyld_word;
         merged_word.meta = meta_q;
         merged_valid     = pyld_valid;
         hdr_ready        = 1'b0;
         pyld_ready       = merged_ready;
      end
   end

   // ----------------------------------------
   // state machine
   // ----------------------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         join_pkg::seq_header: begin
            if (hdr_take && hdr_word.last) begin
               state_nxt = join_pkg::seq_payload;
            end
         end
         join_pkg::seq_payload: begin
            if (pyld_take && pyld_word.last) begin
               state_nxt = join_pkg::seq_header;
            end
         end
         default: state_nxt = join_pkg::seq_header;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= join_pkg::seq_header;
         start <= 1'b1;
      end else begin
         state <= state_nxt;
         if (hdr_take) begin
            start <= 1'b0;
         end else if (pyld_take && pyld_word.last) begin
            start <= 1'b1;
         end
      end
   end

   // capture tid and tdest at packet start.
   always_ff @(posedge clk) begin
      if (hdr_take && start) begin
         meta_q <= hdr_word.meta;
      end
   end

endmodule

// File: tb_stream_join.sv
// ----------------------------------------
// self-checking testbench for the header
// and payload stream join.
// ----------------------------------------

`timescale 1ns/1ps

module tb_stream_join;

   localparam int timeout_cycles = 200;
   localparam int num_rows       = 5;

   // one packet of the table.
   typedef struct packed {
      logic [7:0] hdr_len;
      logic [7:0] pyld_len;
      logic [3:0] tid;
      logic [3:0] tdest;
   } packet_row_t;

   logic                   clk = 1'b0;
   logic                   resetn;
   join_pkg::stream_word_t hdr_word;
   logic                   hdr_valid;
   logic                   hdr_ready;
   join_pkg::stream_word_t pyld_word;
   logic                   pyld_valid;
   logic                   pyld_ready;
   join_pkg::stream_word_t out_word;
   logic                   out_valid;
   logic                   out_ready;

   packet_row_t            table_rows [num_rows];
   packet_row_t            exp_rows [$];
   packet_row_t            cur_row;
   logic [7:0]             exp_bytes [$];
   join_pkg::stream_meta_t row_meta;
   logic [31:0]            data_rng  = 32'd13;
   logic [31:0]            ready_rng = 32'd13;
   logic                   random_ready = 1'b0;
   logic                   first_offer  = 1'b0;
   int                     rem_bytes = 0;
   int                     errors    = 0;
   int                     words_seen = 0;
   int                     waited;

   stream_join stream_join_inst (
      .clk        (clk),
      .resetn     (resetn),
      .hdr_word   (hdr_word),
      .hdr_valid  (hdr_valid),
      .hdr_ready  (hdr_ready),
      .pyld_word  (pyld_word),
      .pyld_valid (pyld_valid),
      .pyld_ready (pyld_ready),
      .out_word   (out_word),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // lowest cnt bytes valid.
   function automatic logic [7:0] keep_of(input int cnt);
      return 8'((9'd1 << cnt) - 9'd1);
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
         input logic [63:0] act);
      if (exp !== act) begin
         $display("FAIL %s expected %0h actual %0h", name, exp, act);
         errors++;
      end
   endtask

   task automatic fill_table();
      // aligned, exact fit, single word, flush of 4 and flush of 1.
      table_rows[0] = {8'd16, 8'd20, 4'h1, 4'h2};
      table_rows[1] = {8'd3,  8'd21, 4'h3, 4'h4};
      table_rows[2] = {8'd2,  8'd3,  4'h5, 4'h6};
      table_rows[3] = {8'd7,  8'd13, 4'h7, 4'h8};
      table_rows[4] = {8'd10, 8'd7,  4'h9, 4'ha};
   endtask

   // ----------------------------------------
   // input drivers
   // ----------------------------------------

   task automatic drive_stream(input bit hdr_sel, input int nbytes,
         input join_pkg::stream_meta_t meta);
      join_pkg::stream_word_t w;
      int   left;
      int   cnt;
      int   wait_cnt;
      logic ready;
      left = nbytes;
      while (left > 0) begin
         cnt = (left > 8) ? 8 : left;
         w   = '0;
         for (int i = 0; i < cnt; i++) begin
            data_rng  = xorshift(data_rng);
            w.data[i] = data_rng[7:0];
            w.keep[i] = 1'b1;
            exp_bytes.push_back(data_rng[7:0]);
         end
         w.last = (left == cnt);
         // only the first header word carries the packet sideband.
         w.meta = (hdr_sel && left == nbytes) ? meta : ~meta;
         @(negedge clk);
         if (hdr_sel) begin
            hdr_word  = w;
            hdr_valid = 1'b1;
         end else begin
            pyld_word  = w;
            pyld_valid = 1'b1;
         end
         wait_cnt = 0;
         #10;
         ready = hdr_sel ? hdr_ready : pyld_ready;
         if (hdr_sel && first_offer) begin
            check_value("hdr_ready", 1, ready);
            first_offer = 1'b0;
         end
         while (!ready && wait_cnt < timeout_cycles) begin
            @(negedge clk);
            #10;
            ready = hdr_sel ? hdr_ready : pyld_ready;
            wait_cnt++;
         end
         if (!ready) begin
            $display("ERROR: timed out waiting for %s ready", hdr_sel ? "header" : "payload");
            errors++;
         end
         if (hdr_sel) begin
            check_value("pyld_ready", 0, pyld_ready);
         end
         @(posedge clk);
         left = left - cnt;
      end
      @(negedge clk);
      hdr_valid  = 1'b0;
      pyld_valid = 1'b0;
   endtask

   // ----------------------------------------
   // output monitor
   // ----------------------------------------

   task automatic check_output_word();
      int cnt;
      if (rem_bytes == 0) begin
         if (exp_rows.size() == 0) begin
            $display("ERROR: output word arrived with no packet pending");
            errors++;
            return;
         end
         cur_row   = exp_rows.pop_front();
         rem_bytes = cur_row.hdr_len + cur_row.pyld_len;
      end
      cnt = (rem_bytes > 8) ? 8 : rem_bytes;
      check_value("out_word.keep", keep_of(cnt), out_word.keep);
      check_value("out_word.last", rem_bytes <= 8, out_word.last);
      check_value("out_word.tid", cur_row.tid, out_word.meta.tid);
      check_value("out_word.tdest", cur_row.tdest, out_word.meta.tdest);
      for (int i = 0; i < cnt; i++) begin
         if (exp_bytes.size() == 0) begin
            $display("ERROR: output carries more bytes than were sent");
            errors++;
         end else begin
            check_value($sformatf("out_word.data[%0d]", i), exp_bytes.pop_front(),
                        out_word.data[i]);
         end
      end
      rem_bytes = rem_bytes - cnt;
      words_seen++;
   endtask

   // outputs are registered, so they hold from here to the next rising edge.
   always @(negedge clk) begin
      if (random_ready) begin
         ready_rng = xorshift(ready_rng);
         out_ready = ready_rng[0];
      end else begin
         out_ready = 1'b1;
      end
      if (resetn && out_valid && out_ready) begin
         check_output_word();
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   initial begin
      fill_table();
      resetn     = 1'b0;
      hdr_word   = '0;
      hdr_valid  = 1'b0;
      pyld_word  = '0;
      pyld_valid = 1'b0;
      out_ready  = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
      // idle with no input valid.
      repeat (4) begin
         @(negedge clk);
         check_value("out_valid", 0, out_valid);
      end
      first_offer = 1'b1;
      // second pass runs with random back-pressure.
      for (int pass = 0; pass < 2; pass++) begin
         random_ready = (pass == 1);
         for (int r = 0; r < num_rows; r++) begin
            exp_rows.push_back(table_rows[r]);
            row_meta.tid   = table_rows[r].tid;
            row_meta.tdest = table_rows[r].tdest;
            drive_stream(1'b1, table_rows[r].hdr_len, row_meta);
            drive_stream(1'b0, table_rows[r].pyld_len, row_meta);
         end
      end
      waited = 0;
      while ((exp_rows.size() != 0 || rem_bytes != 0) && waited < timeout_cycles) begin
         @(negedge clk);
         waited++;
      end
      if (exp_rows.size() != 0 || rem_bytes != 0 || exp_bytes.size() != 0) begin
         $display("ERROR: timed out waiting for the output to drain");
         errors++;
      end
      $display("done: %0d output words, %0d errors", words_seen, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: verilog.f
join_pkg.sv
stream_sequencer.sv
byte_packer.sv
skid_buffer.sv
stream_join.sv
tb_stream_join.sv
